// File: pulse_defs.svh
`ifndef PULSE_DEFS_SVH
`define PULSE_DEFS_SVH

// time values are counted in clk cycles
`define PULSE_CNT_W   32
`define ATT_W         7

// attenuator codes
`define ATT_ON        7'h7f
`define ATT_OFF       7'h00

// timing register defaults, 20000 cycles is one 1 ms shot at 20 MHz
`define DEF_PERIOD    32'd20000
`define DEF_P1WIDTH   32'd30
`define DEF_P2WIDTH   32'd30
`define DEF_DELAY     32'd200
`define DEF_ATT_DELAY 32'd2000
`define DEF_BLOCK     32'd50

// mode defaults
`define DEF_PUMP      1'b1
`define DEF_DOUBLE    1'b1

// edge times that follow from the defaults
`define DEF_P2START   (`DEF_P1WIDTH + `DEF_DELAY)
`define DEF_SYNC_UP   (`DEF_P2START + `DEF_P2WIDTH)
`define DEF_ATT_DOWN  (`DEF_SYNC_UP + `DEF_ATT_DELAY)

`endif

// File: pulse_pkg.sv
`default_nettype none

package pulse_pkg;

   // host register map
   typedef enum logic [3:0] {
      REG_PERIOD    = 4'd0, // shot length
      REG_P1WIDTH   = 4'd1, // first sub-pulse width
      REG_P2WIDTH   = 4'd2, // second sub-pulse width
      REG_DELAY     = 4'd3, // gap between sub-pulses
      REG_ATT_DELAY = 4'd4, // sync start to attenuator release
      REG_BLOCK     = 4'd5, // inhibit hold after sync start
      REG_MODE      = 4'd6, // bit 0 pump, bit 1 double
      REG_PP_PUMP   = 4'd7, // att1 code in pump shots
      REG_PP_PROBE  = 4'd8, // att1 code in probe shots
      REG_POST_ATT  = 4'd9  // code after release
   } reg_addr_e;

   // kind of the shot in progress
   typedef enum logic {
      SHOT_PROBE = 1'b0,
      SHOT_PUMP  = 1'b1
   } shot_e;

   // shot timer FSM
   typedef enum logic {
      T_IDLE = 1'b0,
      T_RUN  = 1'b1
   } timer_state_e;

endpackage

`default_nettype wire

// File: pulse_cfg_regs.sv
`default_nettype none
`include "pulse_defs.svh"

module pulse_cfg_regs (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    cfg_write,
   input  pulse_pkg::reg_addr_e    cfg_addr,
   input  logic [`PULSE_CNT_W-1:0] cfg_wdata,
   output logic [`PULSE_CNT_W-1:0] period,
   output logic [`PULSE_CNT_W-1:0] p1width,
   output logic [`PULSE_CNT_W-1:0] p2width,
   output logic [`PULSE_CNT_W-1:0] block,
   output logic [`PULSE_CNT_W-1:0] p2start,
   output logic [`PULSE_CNT_W-1:0] sync_up,
   output logic [`PULSE_CNT_W-1:0] att_down,
   output logic                    pump_mode,
   output logic                    double_mode,
   output logic [`ATT_W-1:0]       pp_pump,
   output logic [`ATT_W-1:0]       pp_probe,
   output logic [`ATT_W-1:0]       post_att
);

   import pulse_pkg::*;

   logic [`PULSE_CNT_W-1:0] delay;      // gap from end of p1 to start of p2
   logic [`PULSE_CNT_W-1:0] att_delay;  // sync start to attenuator release
   logic [`PULSE_CNT_W-1:0] p2start_c;
   logic [`PULSE_CNT_W-1:0] sync_up_c;
   logic [`PULSE_CNT_W-1:0] att_down_c;

   // stored registers
   always_ff @(posedge clk) begin
      if (reset) begin
         period      <= `DEF_PERIOD;
         p1width     <= `DEF_P1WIDTH;
         p2width     <= `DEF_P2WIDTH;
         delay       <= `DEF_DELAY;
         att_delay   <= `DEF_ATT_DELAY;
         block       <= `DEF_BLOCK;
         pump_mode   <= `DEF_PUMP;
         double_mode <= `DEF_DOUBLE;
         pp_pump     <= `ATT_OFF;  // pump shots open the path
         pp_probe    <= `ATT_ON;
         post_att    <= `ATT_ON;
      end else if (cfg_write) begin
         case (cfg_addr)
            REG_PERIOD:    period    <= cfg_wdata;
            REG_P1WIDTH:   p1width   <= cfg_wdata;
            REG_P2WIDTH:   p2width   <= cfg_wdata;
            REG_DELAY:     delay     <= cfg_wdata;
            REG_ATT_DELAY: att_delay <= cfg_wdata;
            REG_BLOCK:     block     <= cfg_wdata;
            REG_MODE: begin
               pump_mode   <= cfg_wdata[0];
               double_mode <= cfg_wdata[1];
            end
            REG_PP_PUMP:   pp_pump   <= cfg_wdata[`ATT_W-1:0];
            REG_PP_PROBE:  pp_probe  <= cfg_wdata[`ATT_W-1:0];
            REG_POST_ATT:  post_att  <= cfg_wdata[`ATT_W-1:0];
            default: ;  // unmapped address, write dropped
         endcase
      end
   end

   // edge times chained from the stored widths and delays
   always_comb begin
      p2start_c  = p1width + delay;
      sync_up_c  = p2start_c + p2width;
      att_down_c = sync_up_c + att_delay;
   end

   // derived times settle one cycle after a write
   always_ff @(posedge clk) begin
      if (reset) begin
         p2start  <= `DEF_P2START;
         sync_up  <= `DEF_SYNC_UP;
         att_down <= `DEF_ATT_DOWN;
      end else begin
         p2start  <= p2start_c;
         sync_up  <= sync_up_c;
         att_down <= att_down_c;
      end
   end

endmodule

`default_nettype wire

// File: pulse_period_timer.sv
`default_nettype none
`include "pulse_defs.svh"

module pulse_period_timer (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    run,
   input  logic [`PULSE_CNT_W-1:0] period,
   input  logic [`PULSE_CNT_W-1:0] p1width,
   input  logic [`PULSE_CNT_W-1:0] p2width,
   input  logic [`PULSE_CNT_W-1:0] p2start,
   input  logic [`PULSE_CNT_W-1:0] sync_up,
   input  logic [`PULSE_CNT_W-1:0] att_down,
   input  logic [`PULSE_CNT_W-1:0] block,
   input  logic                    pump_mode,
   input  logic                    double_mode,
   input  logic [`ATT_W-1:0]       pp_pump,
   input  logic [`ATT_W-1:0]       pp_probe,
   input  logic [`ATT_W-1:0]       post_att,
   output logic [`PULSE_CNT_W-1:0] phase,
   output pulse_pkg::shot_e        shot,
   output logic                    active,
   output logic [`PULSE_CNT_W-1:0] lat_p1width,
   output logic [`PULSE_CNT_W-1:0] lat_p2width,
   output logic [`PULSE_CNT_W-1:0] lat_p2start,
   output logic [`PULSE_CNT_W-1:0] lat_sync_up,
   output logic [`PULSE_CNT_W-1:0] lat_att_down,
   output logic [`PULSE_CNT_W-1:0] lat_block,
   output logic                    lat_double,
   output logic [`ATT_W-1:0]       lat_pp_pump,
   output logic [`ATT_W-1:0]       lat_pp_probe,
   output logic [`ATT_W-1:0]       lat_post_att
);

   import pulse_pkg::*;

   timer_state_e            state;
   logic [`PULSE_CNT_W-1:0] lat_period;  // length of the shot in progress
   logic                    shot_last;   // final cycle of the shot
   logic                    shot_start;  // next edge begins a shot

   assign shot_last  = (phase + 1'b1 >= lat_period);  // also covers period 0 and 1
   assign shot_start = run && ((state == T_IDLE) || shot_last);
   assign active     = (state == T_RUN);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= T_IDLE;
         phase <= '0;
         shot  <= SHOT_PROBE;
      end else begin
         case (state)
            T_IDLE: begin
               phase <= '0;
               if (run) begin
                  state <= T_RUN;
                  shot  <= pump_mode ? SHOT_PUMP : SHOT_PROBE;  // first shot pumps
               end
            end
            T_RUN: begin
               if (shot_last) begin
                  phase <= '0;
                  if (run) begin
                     shot <= (pump_mode && shot == SHOT_PROBE) ? SHOT_PUMP : SHOT_PROBE;
                  end else begin
                     state <= T_IDLE;  // run dropped, stop at shot end
                  end
               end else begin
                  phase <= phase + 1'b1;
               end
            end
            default: state <= T_IDLE;
         endcase
      end
   end

   // snapshot so host writes never tear a shot
   always_ff @(posedge clk) begin
      if (shot_start) begin
         lat_period   <= period;
         lat_p1width  <= p1width;
         lat_p2width  <= p2width;
         lat_p2start  <= p2start;
         lat_sync_up  <= sync_up;
         lat_att_down <= att_down;
         lat_block    <= block;
         lat_double   <= double_mode;
         lat_pp_pump  <= pp_pump;
         lat_pp_probe <= pp_probe;
         lat_post_att <= post_att;
      end
   end

endmodule

`default_nettype wire

// File: pulse_shaper.sv
`default_nettype none
`include "pulse_defs.svh"

module pulse_shaper (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`PULSE_CNT_W-1:0] phase,
   input  logic                    active,
   input  logic [`PULSE_CNT_W-1:0] p1width,
   input  logic [`PULSE_CNT_W-1:0] p2width,
   input  logic [`PULSE_CNT_W-1:0] p2start,
   input  logic [`PULSE_CNT_W-1:0] sync_up,
   input  logic [`PULSE_CNT_W-1:0] att_down,
   input  logic [`PULSE_CNT_W-1:0] block,
   input  logic                    double_mode,
   output logic                    pulse,
   output logic                    sync,
   output logic                    inhib,
   output logic                    record_start
);

   logic [`PULSE_CNT_W-1:0] p2_end;     // first cycle after sub-pulse 2
   logic [`PULSE_CNT_W-1:0] inhib_end;  // first cycle after inhibit
   logic                    in_p1;
   logic                    in_p2;
   logic                    in_sync;
   logic                    in_inhib;
   logic                    at_sync;

   assign p2_end    = p2start + p2width;
   assign inhib_end = sync_up + block;

   always_comb begin
      in_p1    = (phase < p1width);
      in_p2    = double_mode && (phase >= p2start) && (phase < p2_end);
      in_sync  = (phase >= sync_up) && (phase < att_down);
      in_inhib = (phase < inhib_end);
      at_sync  = (phase == sync_up);  // single cycle per shot
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pulse        <= 1'b0;
         sync         <= 1'b0;
         inhib        <= 1'b0;
         record_start <= 1'b0;
      end else if (!active) begin
         pulse        <= 1'b0;  // quiet between runs
         sync         <= 1'b0;
         inhib        <= 1'b0;
         record_start <= 1'b0;
      end else begin
         pulse        <= in_p1 || in_p2;
         sync         <= in_sync;
         inhib        <= in_inhib;
         record_start <= at_sync;
      end
   end

endmodule

`default_nettype wire

// File: att_ctrl.sv
`default_nettype none
`include "pulse_defs.svh"

module att_ctrl (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`PULSE_CNT_W-1:0] phase,
   input  logic                    active,
   input  pulse_pkg::shot_e        shot,
   input  logic [`PULSE_CNT_W-1:0] att_down,
   input  logic [`ATT_W-1:0]       pp_pump,
   input  logic [`ATT_W-1:0]       pp_probe,
   input  logic [`ATT_W-1:0]       post_att,
   output logic [`ATT_W-1:0]       att1,
   output logic [`ATT_W-1:0]       att3,
   output logic                    pump_on
);

   import pulse_pkg::*;

   logic             is_pump;
   logic             before_rel;  // still ahead of attenuator release
   logic [`ATT_W-1:0] shot_code;

   assign is_pump    = (shot == SHOT_PUMP);
   assign before_rel = (phase < att_down);
   assign shot_code  = is_pump ? pp_pump : pp_probe;

   always_ff @(posedge clk) begin
      if (reset) begin
         att1    <= `ATT_OFF;
         att3    <= `ATT_OFF;
         pump_on <= 1'b0;
      end else if (!active) begin
         att1    <= `ATT_OFF;
         att3    <= `ATT_OFF;
         pump_on <= 1'b0;
      end else begin
         pump_on <= is_pump;
         if (before_rel) begin
            att1 <= shot_code;
            att3 <= post_att;
         end else begin
            att1 <= post_att;  // released for the rest of the shot
            att3 <= `ATT_OFF;
         end
      end
   end

endmodule

`default_nettype wire

// File: pulse_seq_top.sv
`default_nettype none
`include "pulse_defs.svh"

module pulse_seq_top (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    run,
   input  logic                    cfg_write,
   input  pulse_pkg::reg_addr_e    cfg_addr,
   input  logic [`PULSE_CNT_W-1:0] cfg_wdata,
   output logic                    pulse,
   output logic                    sync,
   output logic                    inhib,
   output logic                    record_start,
   output logic                    pump_on,
   output logic [`ATT_W-1:0]       att1,
   output logic [`ATT_W-1:0]       att3
);

   import pulse_pkg::*;

   // host side settings
   logic [`PULSE_CNT_W-1:0] period;
   logic [`PULSE_CNT_W-1:0] p1width;
   logic [`PULSE_CNT_W-1:0] p2width;
   logic [`PULSE_CNT_W-1:0] block;
   logic [`PULSE_CNT_W-1:0] p2start;
   logic [`PULSE_CNT_W-1:0] sync_up;
   logic [`PULSE_CNT_W-1:0] att_down;
   logic                    pump_mode;
   logic                    double_mode;
   logic [`ATT_W-1:0]       pp_pump;
   logic [`ATT_W-1:0]       pp_probe;
   logic [`ATT_W-1:0]       post_att;

   // per shot copies
   logic [`PULSE_CNT_W-1:0] lat_p1width;
   logic [`PULSE_CNT_W-1:0] lat_p2width;
   logic [`PULSE_CNT_W-1:0] lat_p2start;
   logic [`PULSE_CNT_W-1:0] lat_sync_up;
   logic [`PULSE_CNT_W-1:0] lat_att_down;
   logic [`PULSE_CNT_W-1:0] lat_block;
   logic                    lat_double;
   logic [`ATT_W-1:0]       lat_pp_pump;
   logic [`ATT_W-1:0]       lat_pp_probe;
   logic [`ATT_W-1:0]       lat_post_att;

   logic [`PULSE_CNT_W-1:0] phase;
   shot_e                   shot;
   logic                    active;

   pulse_cfg_regs cfg_regs_i (
      .clk         (clk),
      .reset       (reset),
      .cfg_write   (cfg_write),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .period      (period),
      .p1width     (p1width),
      .p2width     (p2width),
      .block       (block),
      .p2start     (p2start),
      .sync_up     (sync_up),
      .att_down    (att_down),
      .pump_mode   (pump_mode),
      .double_mode (double_mode),
      .pp_pump     (pp_pump),
      .pp_probe    (pp_probe),
      .post_att    (post_att)
   );

   pulse_period_timer timer_i (
      .clk          (clk),
      .reset        (reset),
      .run          (run),
      .period       (period),
      .p1width      (p1width),
      .p2width      (p2width),
      .p2start      (p2start),
      .sync_up      (sync_up),
      .att_down     (att_down),
      .block        (block),
      .pump_mode    (pump_mode),
      .double_mode  (double_mode),
      .pp_pump      (pp_pump),
      .pp_probe     (pp_probe),
      .post_att     (post_att),
      .phase        (phase),
      .shot         (shot),
      .active       (active),
      .lat_p1width  (lat_p1width),
      .lat_p2width  (lat_p2width),
      .lat_p2start  (lat_p2start),
      .lat_sync_up  (lat_sync_up),
      .lat_att_down (lat_att_down),
      .lat_block    (lat_block),
      .lat_double   (lat_double),
      .lat_pp_pump  (lat_pp_pump),
      .lat_pp_probe (lat_pp_probe),
      .lat_post_att (lat_post_att)
   );

   pulse_shaper shaper_i (
      .clk          (clk),
      .reset        (reset),
      .phase        (phase),
      .active       (active),
      .p1width      (lat_p1width),
      .p2width      (lat_p2width),
      .p2start      (lat_p2start),
      .sync_up      (lat_sync_up),
      .att_down     (lat_att_down),
      .block        (lat_block),
      .double_mode  (lat_double),
      .pulse        (pulse),
      .sync         (sync),
      .inhib        (inhib),
      .record_start (record_start)
   );

   att_ctrl att_ctrl_i (
      .clk      (clk),
      .reset    (reset),
      .phase    (phase),
      .active   (active),
      .shot     (shot),
      .att_down (lat_att_down),
      .pp_pump  (lat_pp_pump),
      .pp_probe (lat_pp_probe),
      .post_att (lat_post_att),
      .att1     (att1),
      .att3     (att3),
      .pump_on  (pump_on)
   );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam time HALF_PERIOD = 20ns;  // 40 ns period

   initial begin
      clk = 1'b0;
      forever begin
         #(HALF_PERIOD) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

// File: tb_pulse_seq.sv
`default_nettype none
`include "pulse_defs.svh"

module tb_pulse_seq;

   timeunit 1ns;
   timeprecision 100ps;

   import pulse_pkg::*;

   localparam int RESET_CYCLES   = 10;
   localparam int MAX_SHOTS      = 20;
   localparam int MAX_SHOT_LEN   = 400;
   localparam int MARGIN_CYCLES  = 4000;
   localparam int TIMEOUT_CYCLES = MAX_SHOTS * MAX_SHOT_LEN + MARGIN_CYCLES;
   localparam int WRITE_CYCLE    = 5;  // shot cycle of in-shot writes

   logic                    clk;
   logic                    reset;
   logic                    run;
   logic                    cfg_write;
   reg_addr_e               cfg_addr;
   logic [`PULSE_CNT_W-1:0] cfg_wdata;
   logic                    pulse;
   logic                    sync;
   logic                    inhib;
   logic                    record_start;
   logic                    pump_on;
   logic [`ATT_W-1:0]       att1;
   logic [`ATT_W-1:0]       att3;

   // input values for the next rising edge
   logic                    reset_req;
   logic                    run_req;
   logic                    wr_pending;
   reg_addr_e               wr_addr;
   logic [`PULSE_CNT_W-1:0] wr_data;

   logic prev_pulse;  // pins at the previous falling edge
   logic prev_inhib;
   int   cycle_cnt = 0;
   int   test_errors;
   int   total_errors;
   int   tests_passed;
   int   tests_failed;
   int   pulse_rises;

   // register bank contents as the host wrote them
   logic [`PULSE_CNT_W-1:0] h_period;
   logic [`PULSE_CNT_W-1:0] h_p1;
   logic [`PULSE_CNT_W-1:0] h_p2;
   logic [`PULSE_CNT_W-1:0] h_delay;
   logic [`PULSE_CNT_W-1:0] h_attd;
   logic [`PULSE_CNT_W-1:0] h_block;
   logic                    h_pump;
   logic                    h_double;
   logic [`ATT_W-1:0]       h_pp_pump;
   logic [`ATT_W-1:0]       h_pp_probe;
   logic [`ATT_W-1:0]       h_post;

   // settings in force for the shot being checked
   logic [`PULSE_CNT_W-1:0] s_period;
   logic [`PULSE_CNT_W-1:0] s_p1;
   logic [`PULSE_CNT_W-1:0] s_p2;
   logic [`PULSE_CNT_W-1:0] s_delay;
   logic [`PULSE_CNT_W-1:0] s_attd;
   logic [`PULSE_CNT_W-1:0] s_block;
   logic                    s_double;
   logic                    s_pump_shot;
   logic [`ATT_W-1:0]       s_pp_pump;
   logic [`ATT_W-1:0]       s_pp_probe;
   logic [`ATT_W-1:0]       s_post;
   logic                    first_shot;

   tb_clock_gen clock_gen_i (
      .clk (clk)
   );

   pulse_seq_top pulse_seq_top_i (
      .clk          (clk),
      .reset        (reset),
      .run          (run),
      .cfg_write    (cfg_write),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .pulse        (pulse),
      .sync         (sync),
      .inhib        (inhib),
      .record_start (record_start),
      .pump_on      (pump_on),
      .att1         (att1),
      .att3         (att3)
   );

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // drive on the rising edge and sample at the falling edge
   task automatic next_cycle();
      prev_pulse = pulse;
      prev_inhib = inhib;
      @(posedge clk);
      reset <= reset_req;
      run   <= run_req;
      if (wr_pending) begin
         cfg_write  <= 1'b1;
         cfg_addr   <= wr_addr;
         cfg_wdata  <= wr_data;
         wr_pending = 1'b0;
      end else begin
         cfg_write <= 1'b0;
      end
      @(negedge clk);
   endtask

   task automatic note_write(input reg_addr_e addr, input logic [`PULSE_CNT_W-1:0] data);
      case (addr)
         REG_PERIOD:    h_period = data;
         REG_P1WIDTH:   h_p1     = data;
         REG_P2WIDTH:   h_p2     = data;
         REG_DELAY:     h_delay  = data;
         REG_ATT_DELAY: h_attd   = data;
         REG_BLOCK:     h_block  = data;
         REG_MODE: begin
            h_pump   = data[0];
            h_double = data[1];
         end
         REG_PP_PUMP:   h_pp_pump  = data[`ATT_W-1:0];
         REG_PP_PROBE:  h_pp_probe = data[`ATT_W-1:0];
         REG_POST_ATT:  h_post     = data[`ATT_W-1:0];
         default: ;
      endcase
   endtask

   task automatic queue_write(input reg_addr_e addr, input logic [`PULSE_CNT_W-1:0] data);
      wr_pending = 1'b1;
      wr_addr    = addr;
      wr_data    = data;
      note_write(addr, data);
   endtask

   task automatic host_write(input reg_addr_e addr, input logic [`PULSE_CNT_W-1:0] data);
      queue_write(addr, data);
      next_cycle();
   endtask

   task automatic do_reset();
      reset_req = 1'b1;
      run_req   = 1'b0;
      repeat (RESET_CYCLES) next_cycle();
      reset_req = 1'b0;
      next_cycle();
      h_period   = `DEF_PERIOD;
      h_p1       = `DEF_P1WIDTH;
      h_p2       = `DEF_P2WIDTH;
      h_delay    = `DEF_DELAY;
      h_attd     = `DEF_ATT_DELAY;
      h_block    = `DEF_BLOCK;
      h_pump     = `DEF_PUMP;
      h_double   = `DEF_DOUBLE;
      h_pp_pump  = `ATT_OFF;
      h_pp_probe = `ATT_ON;
      h_post     = `ATT_ON;
   endtask

   task automatic start_run();
      repeat (3) next_cycle();  // let the derived edge times settle
      run_req    = 1'b1;
      first_shot = 1'b1;
      next_cycle();
   endtask

   // first rise of pulse in a shot with inhib low the cycle before
   task automatic wait_shot_start();
      while (!(pulse && !prev_pulse && !prev_inhib)) begin
         next_cycle();
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_all_pins(input logic e_pulse, input logic e_sync, input logic e_inhib,
                                 input logic e_rec, input logic e_pump,
                                 input logic [`ATT_W-1:0] e_att1, input logic [`ATT_W-1:0] e_att3);
      check_value("pulse", pulse, e_pulse);
      check_value("sync", sync, e_sync);
      check_value("inhib", inhib, e_inhib);
      check_value("record_start", record_start, e_rec);
      check_value("pump_on", pump_on, e_pump);
      check_value("att1", att1, e_att1);
      check_value("att3", att3, e_att3);
   endtask

   // one whole shot from its first cycle up to the next shot's first cycle
   task automatic check_shot(input logic do_wr, input reg_addr_e addr,
                             input logic [`PULSE_CNT_W-1:0] data);
      logic [`PULSE_CNT_W-1:0] p2start;
      logic [`PULSE_CNT_W-1:0] sync_up;
      logic [`PULSE_CNT_W-1:0] att_down;
      logic [`ATT_W-1:0]       code;
      int                      k;
      s_period   = h_period;
      s_p1       = h_p1;
      s_p2       = h_p2;
      s_delay    = h_delay;
      s_attd     = h_attd;
      s_block    = h_block;
      s_double   = h_double;
      s_pp_pump  = h_pp_pump;
      s_pp_probe = h_pp_probe;
      s_post     = h_post;
      s_pump_shot = first_shot ? h_pump : (h_pump && !s_pump_shot);  // pump, probe, pump
      first_shot  = 1'b0;
      p2start  = s_p1 + s_delay;
      sync_up  = p2start + s_p2;
      att_down = sync_up + s_attd;
      code     = s_pump_shot ? s_pp_pump : s_pp_probe;
      pulse_rises = 0;
      for (k = 0; k < s_period; k++) begin
         check_all_pins((k < s_p1) || (s_double && k >= p2start && k < p2start + s_p2),
                        (k >= sync_up) && (k < att_down),
                        (k < sync_up + s_block),
                        (k == sync_up),
                        s_pump_shot,
                        (k < att_down) ? code : s_post,
                        (k < att_down) ? s_post : `ATT_OFF);
         if (pulse && !prev_pulse) pulse_rises++;
         if (do_wr && k == WRITE_CYCLE) queue_write(addr, data);
         next_cycle();
      end
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, test_errors);
      end
      total_errors += test_errors;
      test_errors  = 0;
   endtask

   task automatic test_reset_state();
      do_reset();
      repeat (8) begin
         check_all_pins(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, `ATT_OFF, `ATT_OFF);
         next_cycle();
      end
      finish_test("reset state");
   endtask

   task automatic test_default_shape();
      do_reset();
      host_write(REG_PERIOD, 32'd400);
      host_write(REG_ATT_DELAY, 32'd100);  // release at 360 inside the shot
      start_run();
      wait_shot_start();
      repeat (2) check_shot(1'b0, REG_PERIOD, '0);
      finish_test("default shape");
   endtask

   task automatic test_single_pulse();
      logic [`PULSE_CNT_W-1:0] new_p1;
      new_p1 = 32'd40 + ($urandom % 60);
      do_reset();
      host_write(REG_PERIOD, 32'd400);
      host_write(REG_MODE, 32'h1);  // pump on, double off
      start_run();
      wait_shot_start();
      check_shot(1'b1, REG_P1WIDTH, new_p1);
      check_value("pulse rise count", pulse_rises, 1);
      repeat (2) begin
         check_shot(1'b0, REG_PERIOD, '0);
         check_value("pulse rise count", pulse_rises, 1);
      end
      finish_test("single pulse");
   endtask

   task automatic test_pump_alternation();
      do_reset();
      host_write(REG_PERIOD, 32'd400);
      host_write(REG_ATT_DELAY, 32'd100);
      start_run();
      wait_shot_start();
      repeat (3) check_shot(1'b0, REG_PERIOD, '0);
      check_shot(1'b1, REG_MODE, 32'h2);  // pump off from the next shot
      repeat (2) check_shot(1'b0, REG_PERIOD, '0);
      finish_test("pump alternation");
   endtask

   task automatic test_att_release();
      logic [`PULSE_CNT_W-1:0] att_delay;
      logic [`PULSE_CNT_W-1:0] post;
      att_delay = 32'd1 + ($urandom % 120);
      post      = 32'h40 + ($urandom % 64);
      do_reset();
      host_write(REG_PERIOD, 32'd400);
      host_write(REG_ATT_DELAY, att_delay);
      host_write(REG_PP_PUMP, 32'h11);
      host_write(REG_PP_PROBE, 32'h22);
      host_write(REG_POST_ATT, post);
      start_run();
      wait_shot_start();
      repeat (2) check_shot(1'b0, REG_PERIOD, '0);
      finish_test("attenuator release");
   endtask

   task automatic test_mid_shot_write();
      do_reset();
      host_write(REG_PERIOD, 32'd400);
      host_write(REG_ATT_DELAY, 32'd60);
      start_run();
      wait_shot_start();
      check_shot(1'b1, REG_PERIOD, 32'd350);  // current shot stays at 400
      repeat (2) check_shot(1'b0, REG_PERIOD, '0);
      finish_test("mid-shot write");
   endtask

   initial begin
      int unsigned seed;
      seed = 32'h4c2985c8;
      void'($urandom(seed));
      reset      <= 1'b1;
      run        <= 1'b0;
      cfg_write  <= 1'b0;
      cfg_addr   <= REG_PERIOD;
      cfg_wdata  <= '0;
      reset_req  = 1'b1;
      run_req    = 1'b0;
      wr_pending = 1'b0;
      first_shot = 1'b0;
      test_errors  = 0;
      total_errors = 0;
      tests_passed = 0;
      tests_failed = 0;

      test_reset_state();
      test_default_shape();
      test_single_pulse();
      test_pump_alternation();
      test_att_release();
      test_mid_shot_write();

      $display("%0d tests ok, %0d tests failed, %0d errors", tests_passed, tests_failed,
               total_errors);
      if (tests_failed == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
pulse_pkg.sv
pulse_cfg_regs.sv
pulse_period_timer.sv
pulse_shaper.sv
att_ctrl.sv
pulse_seq_top.sv
tb_clock_gen.sv
tb_pulse_seq.sv

// File: Bender.yml
package:
  name: pulse_seq

sources:
  - include_dirs:
      - .
    files:
      - pulse_pkg.sv
      - pulse_cfg_regs.sv
      - pulse_period_timer.sv
      - pulse_shaper.sv
      - att_ctrl.sv
      - pulse_seq_top.sv
      - target: test
        files:
          - tb_clock_gen.sv
          - tb_pulse_seq.sv
